// File: rtl/qsgmii_pkg.sv
`default_nettype none

package qsgmii_pkg;

	////////////////////////////////////////
	// Link geometry

	// Four SGMII ports share one QSGMII lane
	localparam int num_ports      = 4;
	localparam int lane_idx_width = $clog2(num_ports);
	localparam int sym_width      = 8;

	////////////////////////////////////////
	// Special 8b/10b control codes

	// K28.5 is the ordinary comma
	localparam logic [7:0] code_k28_5 = 8'hbc;
	// K28.1 marks the symbol slot of port 0
	localparam logic [7:0] code_k28_1 = 8'h3c;
	// K28.7 also carries a comma
	localparam logic [7:0] code_k28_7 = 8'hfc;
	// Common 5b value of the K28 family
	localparam logic [4:0] k28_x      = 5'd28;

	////////////////////////////////////////
	// Port monitor limits

	localparam int sync_good_commas = 3;
	localparam int sync_bad_limit   = 4;
	localparam int sync_good_width  = $clog2(sync_good_commas);
	localparam int sync_bad_width   = $clog2(sync_bad_limit);
	localparam int err_count_width  = 16;

	////////////////////////////////////////
	// Register map and bus codes

	localparam int axil_addr_width = 8;
	localparam int axil_data_width = 32;

	localparam logic [axil_addr_width-1:0] reg_control  = 'h00;
	localparam logic [axil_addr_width-1:0] reg_status   = 'h04;
	localparam logic [axil_addr_width-1:0] reg_err_base = 'h10;
	localparam int                         reg_err_stride = 4;

	// Bit positions inside the control and status words
	localparam int ctl_clear_bit      = 8;
	localparam int status_aligned_bit = 8;
	localparam int status_base_lsb    = 12;

	localparam logic [1:0] axi_resp_okay   = 2'd0;
	localparam logic [1:0] axi_resp_slverr = 2'd2;

	// Control byte seen whole or as its 3b/5b fields
	typedef union packed {
		logic [7:0] code;
		struct packed {
			logic [2:0] y;
			logic [4:0] x;
		} f;
	} ctl_symbol_t;

endpackage

`default_nettype wire

// File: rtl/qsgmii_lane_splitter.sv
`default_nettype none

module qsgmii_lane_splitter
	import qsgmii_pkg::*;
(
	input wire                                rx_clk,
	input wire                                rst_n,

	// Transceiver side, already 8b/10b decoded
	input wire                                rx_data_valid,
	input wire [num_ports-1:0]                rx_data_is_ctl,
	input wire [num_ports*sym_width-1:0]      rx_data,
	input wire [num_ports-1:0]                rx_disparity_err,
	input wire [num_ports-1:0]                rx_symbol_err,

	// Per-port symbols in port order
	output logic                              sgmii_rx_data_valid,
	output logic [num_ports-1:0]              sgmii_rx_data_is_ctl,
	output logic [num_ports*sym_width-1:0]    sgmii_rx_data,
	output logic [num_ports-1:0]              sgmii_rx_disparity_err,
	output logic [num_ports-1:0]              sgmii_rx_symbol_err,

	// Alignment state
	output logic                              aligned,
	output logic [lane_idx_width-1:0]         base_lane
);

	////////////////////////////////////////
	// Marker search

	ctl_symbol_t                lane_sym    [num_ports];
	logic [num_ports-1:0]       lane_marker;
	logic                       marker_found;
	logic [lane_idx_width-1:0]  marker_lane;
	logic [lane_idx_width-1:0]  next_base;

	for (genvar g = 0; g < num_ports; g++) begin : g_lane
		assign lane_sym[g].code = rx_data[g*sym_width +: sym_width];
		// K28 family by its 5b field, K28.1 by its 3b field
		assign lane_marker[g] = rx_data_valid && rx_data_is_ctl[g] &&
			(lane_sym[g].f.x == k28_x) && (lane_sym[g].f.y == code_k28_1[7:5]);
	end

	// Lowest lane wins if more than one marker shows up in a word
	always_comb begin
		marker_found = 1'b0;
		marker_lane  = '0;
		for (int k = num_ports - 1; k >= 0; k--) begin
			if (lane_marker[k]) begin
				marker_found = 1'b1;
				marker_lane  = lane_idx_width'(k);
			end
		end
	end

	// New base lane applies to the word that carries the marker
	assign next_base = marker_found ? marker_lane : base_lane;

	////////////////////////////////////////
	// Lane rotation

	logic [lane_idx_width-1:0]         src_lane [num_ports];
	logic [num_ports-1:0]              rot_is_ctl;
	logic [num_ports*sym_width-1:0]    rot_data;
	logic [num_ports-1:0]              rot_disp_err;
	logic [num_ports-1:0]              rot_sym_err;

	for (genvar p = 0; p < num_ports; p++) begin : g_port
		// Index wraps modulo the port count
		assign src_lane[p] = lane_idx_width'(p) + next_base;

		// Data, control flag and both error flags move as one
		assign rot_is_ctl[p]   = rx_data_is_ctl[src_lane[p]];
		assign rot_disp_err[p] = rx_disparity_err[src_lane[p]];
		assign rot_sym_err[p]  = rx_symbol_err[src_lane[p]];

		// Every K28.1 goes out as a plain comma
		assign rot_data[p*sym_width +: sym_width] = lane_marker[src_lane[p]] ?
			code_k28_5 : rx_data[src_lane[p]*sym_width +: sym_width];
	end

	////////////////////////////////////////
	// Registers

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			sgmii_rx_data_valid <= 1'b0;
			base_lane           <= '0;
			aligned             <= 1'b0;
		end else begin
			sgmii_rx_data_valid <= rx_data_valid;
			if (marker_found) begin
				base_lane <= marker_lane;
				aligned   <= 1'b1;
			end
		end
	end

	// Symbol payload
	always_ff @(posedge rx_clk) begin
		sgmii_rx_data_is_ctl   <= rot_is_ctl;
		sgmii_rx_data          <= rot_data;
		sgmii_rx_disparity_err <= rot_disp_err;
		sgmii_rx_symbol_err    <= rot_sym_err;
	end

endmodule

`default_nettype wire

// File: rtl/sgmii_port_monitor.sv
`default_nettype none

module sgmii_port_monitor
	import qsgmii_pkg::*;
(
	input wire                          rx_clk,
	input wire                          rst_n,

	// Control from the register block
	input wire                          enable,
	input wire                          clear_counters,

	// One port's symbol stream from the splitter
	input wire                          sym_valid,
	input wire                          sym_is_ctl,
	input wire [sym_width-1:0]          sym_data,
	input wire                          sym_disparity_err,
	input wire                          sym_symbol_err,

	// Status
	output logic                        sync,
	output logic [err_count_width-1:0]  error_count
);

	////////////////////////////////////////
	// Symbol classification

	ctl_symbol_t  sym;
	logic         sym_errored;
	logic         comma_y;
	logic         is_comma;

	assign sym.code = sym_data;

	// Either decoder flag marks the symbol bad
	assign sym_errored = sym_disparity_err || sym_symbol_err;

	// K28.1, K28.5 and K28.7 all hold the comma pattern
	assign comma_y = (sym.f.y == code_k28_1[7:5]) ||
		(sym.f.y == code_k28_5[7:5]) ||
		(sym.f.y == code_k28_7[7:5]);

	assign is_comma = sym_is_ctl && (sym.f.x == k28_x) && comma_y;

	////////////////////////////////////////
	// Sync state machine

	// sync itself is the state bit
	// low is hunting and high is synced
	logic [sync_good_width-1:0]  good_cnt;
	logic [sync_bad_width-1:0]   bad_cnt;
	logic                        sync_nxt;
	logic [sync_good_width-1:0]  good_nxt;
	logic [sync_bad_width-1:0]   bad_nxt;

	always_comb begin
		sync_nxt = sync;
		good_nxt = good_cnt;
		bad_nxt  = bad_cnt;

		if (!enable) begin
			// Held in hunting with counts left as they are
			sync_nxt = 1'b0;
		end else if (sym_valid) begin
			if (!sync) begin
				if (sym_errored) begin
					good_nxt = '0;
				end else if (is_comma) begin
					if (good_cnt == sync_good_width'(sync_good_commas - 1)) begin
						// Third clean comma
						sync_nxt = 1'b1;
						good_nxt = '0;
						bad_nxt  = '0;
					end else begin
						good_nxt = good_cnt + 1'b1;
					end
				end
			end else begin
				if (sym_errored) begin
					if (bad_cnt == sync_bad_width'(sync_bad_limit - 1)) begin
						// Too many bad symbols in a row
						sync_nxt = 1'b0;
						good_nxt = '0;
						bad_nxt  = '0;
					end else begin
						bad_nxt = bad_cnt + 1'b1;
					end
				end else begin
					bad_nxt = '0;
				end
			end
		end
	end

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			sync     <= 1'b0;
			good_cnt <= '0;
			bad_cnt  <= '0;
		end else begin
			sync     <= sync_nxt;
			good_cnt <= good_nxt;
			bad_cnt  <= bad_nxt;
		end
	end

	////////////////////////////////////////
	// Error counter

	// Saturates at all ones, clear wins over counting
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			error_count <= '0;
		end else if (clear_counters) begin
			error_count <= '0;
		end else if (enable && sym_valid && sym_errored && (error_count != '1)) begin
			error_count <= error_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/qsgmii_csr.sv
`default_nettype none

module qsgmii_csr
	import qsgmii_pkg::*;
(
	input wire                          rx_clk,
	input wire                          rst_n,

	// AXI4-Lite write channels
	input wire [axil_addr_width-1:0]    s_axil_awaddr,
	input wire                          s_axil_awvalid,
	output logic                        s_axil_awready,
	input wire [axil_data_width-1:0]    s_axil_wdata,
	input wire [axil_data_width/8-1:0]  s_axil_wstrb,
	input wire                          s_axil_wvalid,
	output logic                        s_axil_wready,
	output logic [1:0]                  s_axil_bresp,
	output logic                        s_axil_bvalid,
	input wire                          s_axil_bready,

	// AXI4-Lite read channels
	input wire [axil_addr_width-1:0]    s_axil_araddr,
	input wire                          s_axil_arvalid,
	output logic                        s_axil_arready,
	output logic [axil_data_width-1:0]  s_axil_rdata,
	output logic [1:0]                  s_axil_rresp,
	output logic                        s_axil_rvalid,
	input wire                          s_axil_rready,

	// Control outputs
	output logic [num_ports-1:0]        port_enable,
	output logic                        clear_counters,

	// Status inputs
	input wire [num_ports-1:0]          sync,
	input wire                          aligned,
	input wire [lane_idx_width-1:0]     base_lane,
	input wire [err_count_width-1:0]    error_count_0,
	input wire [err_count_width-1:0]    error_count_1,
	input wire [err_count_width-1:0]    error_count_2,
	input wire [err_count_width-1:0]    error_count_3
);

	////////////////////////////////////////
	// Address decode

	logic [err_count_width-1:0] err_cnt [num_ports];

	assign err_cnt[0] = error_count_0;
	assign err_cnt[1] = error_count_1;
	assign err_cnt[2] = error_count_2;
	assign err_cnt[3] = error_count_3;

	// True for any register in the map, read-only ones included
	function automatic logic addr_mapped(input logic [axil_addr_width-1:0] addr);
		logic hit;
		hit = (addr == reg_control) || (addr == reg_status);
		for (int i = 0; i < num_ports; i++) begin
			if (addr == axil_addr_width'(reg_err_base + i*reg_err_stride))
				hit = 1'b1;
		end
		return hit;
	endfunction

	logic                        wr_fire;
	logic                        rd_fire;
	logic [axil_data_width-1:0]  rd_word;

	// awready and wready always rise together
	assign wr_fire = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
	assign rd_fire = s_axil_arready && s_axil_arvalid;

	// Read mux, unmapped addresses fall through to zero
	always_comb begin
		rd_word = '0;
		if (s_axil_araddr == reg_control) begin
			rd_word[num_ports-1:0] = port_enable;
		end else if (s_axil_araddr == reg_status) begin
			rd_word[num_ports-1:0]                         = sync;
			rd_word[status_aligned_bit]                    = aligned;
			rd_word[status_base_lsb +: lane_idx_width]     = base_lane;
		end else begin
			for (int i = 0; i < num_ports; i++) begin
				if (s_axil_araddr == axil_addr_width'(reg_err_base + i*reg_err_stride))
					rd_word[err_count_width-1:0] = err_cnt[i];
			end
		end
	end

	////////////////////////////////////////
	// Handshakes and control register

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			s_axil_awready <= 1'b0;
			s_axil_wready  <= 1'b0;
			s_axil_bvalid  <= 1'b0;
			s_axil_arready <= 1'b0;
			s_axil_rvalid  <= 1'b0;
			port_enable    <= '1;
			clear_counters <= 1'b0;
		end else begin
			// One-cycle ready pulse, held off while a response waits
			s_axil_awready <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !s_axil_awready;
			s_axil_wready  <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !s_axil_awready;
			s_axil_arready <= s_axil_arvalid && !s_axil_rvalid && !s_axil_arready;

			// Clear is a single pulse
			clear_counters <= 1'b0;

			if (wr_fire) begin
				s_axil_bvalid <= 1'b1;
				if (s_axil_awaddr == reg_control) begin
					// Byte 0 holds the enables
					if (s_axil_wstrb[0])
						port_enable <= s_axil_wdata[num_ports-1:0];
					// Byte 1 holds the clear bit
					if (s_axil_wstrb[1] && s_axil_wdata[ctl_clear_bit])
						clear_counters <= 1'b1;
				end
			end else if (s_axil_bvalid && s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end

			if (rd_fire)
				s_axil_rvalid <= 1'b1;
			else if (s_axil_rvalid && s_axil_rready)
				s_axil_rvalid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Response payload

	// Captured at the handshake and stable until accepted
	always_ff @(posedge rx_clk) begin
		if (wr_fire)
			s_axil_bresp <= addr_mapped(s_axil_awaddr) ? axi_resp_okay : axi_resp_slverr;
		if (rd_fire) begin
			s_axil_rdata <= rd_word;
			s_axil_rresp <= addr_mapped(s_axil_araddr) ? axi_resp_okay : axi_resp_slverr;
		end
	end

endmodule

`default_nettype wire

// File: rtl/qsgmii_rx_top.sv
`default_nettype none

module qsgmii_rx_top
	import qsgmii_pkg::*;
(
	input wire                          rx_clk,
	input wire                          rst_n,

	// Transceiver inputs
	input wire                          rx_data_valid,
	input wire [num_ports-1:0]          rx_data_is_ctl,
	input wire [num_ports*sym_width-1:0] rx_data,
	input wire [num_ports-1:0]          rx_disparity_err,
	input wire [num_ports-1:0]          rx_symbol_err,

	// Port-ordered symbol outputs
	output wire                         sgmii_rx_data_valid,
	output wire [num_ports-1:0]         sgmii_rx_data_is_ctl,
	output wire [num_ports*sym_width-1:0] sgmii_rx_data,
	output wire [num_ports-1:0]         sgmii_rx_disparity_err,
	output wire [num_ports-1:0]         sgmii_rx_symbol_err,

	// Register bus
	input wire [axil_addr_width-1:0]    s_axil_awaddr,
	input wire                          s_axil_awvalid,
	output wire                         s_axil_awready,
	input wire [axil_data_width-1:0]    s_axil_wdata,
	input wire [axil_data_width/8-1:0]  s_axil_wstrb,
	input wire                          s_axil_wvalid,
	output wire                         s_axil_wready,
	output wire [1:0]                   s_axil_bresp,
	output wire                         s_axil_bvalid,
	input wire                          s_axil_bready,
	input wire [axil_addr_width-1:0]    s_axil_araddr,
	input wire                          s_axil_arvalid,
	output wire                         s_axil_arready,
	output wire [axil_data_width-1:0]   s_axil_rdata,
	output wire [1:0]                   s_axil_rresp,
	output wire                         s_axil_rvalid,
	input wire                          s_axil_rready
);

	////////////////////////////////////////
	// Internal nets

	wire [num_ports-1:0]         port_enable;
	wire                         clear_counters;
	wire [num_ports-1:0]         port_sync;
	wire                         aligned;
	wire [lane_idx_width-1:0]    base_lane;
	wire [err_count_width-1:0]   err_cnt [num_ports];

	// Lane alignment
	qsgmii_lane_splitter u_splitter (
		.rx_clk                 (rx_clk),
		.rst_n                  (rst_n),
		.rx_data_valid          (rx_data_valid),
		.rx_data_is_ctl         (rx_data_is_ctl),
		.rx_data                (rx_data),
		.rx_disparity_err       (rx_disparity_err),
		.rx_symbol_err          (rx_symbol_err),
		.sgmii_rx_data_valid    (sgmii_rx_data_valid),
		.sgmii_rx_data_is_ctl   (sgmii_rx_data_is_ctl),
		.sgmii_rx_data          (sgmii_rx_data),
		.sgmii_rx_disparity_err (sgmii_rx_disparity_err),
		.sgmii_rx_symbol_err    (sgmii_rx_symbol_err),
		.aligned                (aligned),
		.base_lane              (base_lane)
	);

	// One monitor per port, each on its own output lane
	for (genvar g = 0; g < num_ports; g++) begin : g_mon
		sgmii_port_monitor u_monitor (
			.rx_clk            (rx_clk),
			.rst_n             (rst_n),
			.enable            (port_enable[g]),
			.clear_counters    (clear_counters),
			.sym_valid         (sgmii_rx_data_valid),
			.sym_is_ctl        (sgmii_rx_data_is_ctl[g]),
			.sym_data          (sgmii_rx_data[g*sym_width +: sym_width]),
			.sym_disparity_err (sgmii_rx_disparity_err[g]),
			.sym_symbol_err    (sgmii_rx_symbol_err[g]),
			.sync              (port_sync[g]),
			.error_count       (err_cnt[g])
		);
	end

	// Control and status registers
	qsgmii_csr u_csr (
		.rx_clk         (rx_clk),
		.rst_n          (rst_n),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wstrb   (s_axil_wstrb),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready),
		.port_enable    (port_enable),
		.clear_counters (clear_counters),
		.sync           (port_sync),
		.aligned        (aligned),
		.base_lane      (base_lane),
		.error_count_0  (err_cnt[0]),
		.error_count_1  (err_cnt[1]),
		.error_count_2  (err_cnt[2]),
		.error_count_3  (err_cnt[3])
	);

endmodule

`default_nettype wire

// File: dv/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////
// Value compare tasks

// One wrong value ends the run
task automatic report_mismatch(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	$display("CHECKS FAILED");
	$fatal(1, "value check failed");
endtask

// Splitter output word, all four lanes with their flags
task automatic check_lane_word(input logic got_valid, input logic exp_valid,
	input logic [31:0] got_data, input logic [31:0] exp_data,
	input logic [3:0] got_ctl, input logic [3:0] exp_ctl,
	input logic [3:0] got_disp, input logic [3:0] exp_disp,
	input logic [3:0] got_sym, input logic [3:0] exp_sym);
	if (got_valid !== exp_valid)
		report_mismatch("sgmii_rx_data_valid", 32'(got_valid), 32'(exp_valid));
	if (got_data !== exp_data)
		report_mismatch("sgmii_rx_data", got_data, exp_data);
	if (got_ctl !== exp_ctl)
		report_mismatch("sgmii_rx_data_is_ctl", 32'(got_ctl), 32'(exp_ctl));
	if (got_disp !== exp_disp)
		report_mismatch("sgmii_rx_disparity_err", 32'(got_disp), 32'(exp_disp));
	if (got_sym !== exp_sym)
		report_mismatch("sgmii_rx_symbol_err", 32'(got_sym), 32'(exp_sym));
endtask

// Fields of the status register
task automatic check_status(input logic [3:0] got_sync, input logic [3:0] exp_sync,
	input logic got_aligned, input logic exp_aligned,
	input logic [1:0] got_base, input logic [1:0] exp_base);
	if (got_sync !== exp_sync)
		report_mismatch("status.sync", 32'(got_sync), 32'(exp_sync));
	if (got_aligned !== exp_aligned)
		report_mismatch("status.aligned", 32'(got_aligned), 32'(exp_aligned));
	if (got_base !== exp_base)
		report_mismatch("status.base_lane", 32'(got_base), 32'(exp_base));
endtask

task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp)
		report_mismatch(name, 32'(got), 32'(exp));
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
	if (got !== exp)
		report_mismatch(name, 32'(got), 32'(exp));
endtask

// Whole bus data word
task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		report_mismatch(name, got, exp);
endtask

////////////////////////////////////////
// AXI4-Lite bus tasks

// wready has to follow awready on every cycle of the address phase
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
	output logic [1:0] resp);
	@(posedge rx_clk);
	s_axil_awaddr  <= addr;
	s_axil_wdata   <= data;
	s_axil_wstrb   <= 4'hf;
	s_axil_awvalid <= 1'b1;
	s_axil_wvalid  <= 1'b1;
	do begin
		@(negedge rx_clk);
		check_count("s_axil_wready", 16'(s_axil_wready), 16'(s_axil_awready));
	end while (!s_axil_awready);
	@(posedge rx_clk);
	s_axil_awvalid <= 1'b0;
	s_axil_wvalid  <= 1'b0;
	s_axil_bready  <= 1'b1;
	do @(negedge rx_clk); while (!s_axil_bvalid);
	resp = s_axil_bresp;
	@(posedge rx_clk);
	s_axil_bready <= 1'b0;
endtask

// Holds rready low for hold cycles and checks that the data stays put
task automatic read_reg(input logic [7:0] addr, input int hold,
	output logic [31:0] data, output logic [1:0] resp);
	@(posedge rx_clk);
	s_axil_araddr  <= addr;
	s_axil_arvalid <= 1'b1;
	do @(negedge rx_clk); while (!s_axil_arready);
	@(posedge rx_clk);
	s_axil_arvalid <= 1'b0;
	do @(negedge rx_clk); while (!s_axil_rvalid);
	data = s_axil_rdata;
	resp = s_axil_rresp;
	for (int i = 0; i < hold; i++) begin
		@(negedge rx_clk);
		check_word("s_axil_rdata", s_axil_rdata, data);
		check_resp("s_axil_rresp", s_axil_rresp, resp);
		check_count("s_axil_rvalid", 16'(s_axil_rvalid), 16'd1);
	end
	@(posedge rx_clk);
	s_axil_rready <= 1'b1;
	@(posedge rx_clk);
	s_axil_rready <= 1'b0;
endtask

`endif

// File: dv/tb_qsgmii_rx.sv
`default_nettype none

module tb_qsgmii_rx
	import qsgmii_pkg::*;
;

	////////////////////////////////////////
	// Run length and cycle budget

	localparam int n_align   = 400;
	localparam int n_sync    = 300;
	localparam int n_err     = 300;
	localparam int n_dis     = 200;
	localparam int n_idle    = 8;
	localparam int n_bus_ops = 40;
	localparam int bus_cyc   = 30;
	localparam int budget    = 5 + n_align + n_sync + n_err + n_dis + 12*n_idle
		+ n_bus_ops*bus_cyc;
	localparam int cycle_limit = budget + budget/10;

	logic        rx_clk;
	logic        rst_n;
	logic        rx_data_valid;
	logic [3:0]  rx_data_is_ctl;
	logic [31:0] rx_data;
	logic [3:0]  rx_disparity_err;
	logic [3:0]  rx_symbol_err;
	wire         sgmii_rx_data_valid;
	wire [3:0]   sgmii_rx_data_is_ctl;
	wire [31:0]  sgmii_rx_data;
	wire [3:0]   sgmii_rx_disparity_err;
	wire [3:0]   sgmii_rx_symbol_err;
	logic [7:0]  s_axil_awaddr;
	logic        s_axil_awvalid;
	wire         s_axil_awready;
	logic [31:0] s_axil_wdata;
	logic [3:0]  s_axil_wstrb;
	logic        s_axil_wvalid;
	wire         s_axil_wready;
	wire [1:0]   s_axil_bresp;
	wire         s_axil_bvalid;
	logic        s_axil_bready;
	logic [7:0]  s_axil_araddr;
	logic        s_axil_arvalid;
	wire         s_axil_arready;
	wire [31:0]  s_axil_rdata;
	wire [1:0]   s_axil_rresp;
	wire         s_axil_rvalid;
	logic        s_axil_rready;

	integer seed = 25;
	int     cycle_cnt = 0;

	// Reference model state
	logic [3:0]  m_enable;
	int          clr_seq = 0;
	int          clr_seen;
	logic [1:0]  m_base;
	logic        m_aligned;
	logic [3:0]  m_sync;
	int          m_good [4];
	int          m_bad [4];
	logic [15:0] m_cnt [4];
	logic        exp_valid;
	logic [31:0] exp_data;
	logic [3:0]  exp_ctl;
	logic [3:0]  exp_disp;
	logic [3:0]  exp_sym;

	// Error counts as last read over the bus
	logic [15:0] read_cnt [4];

	qsgmii_rx_top i_dut (.*);

	`include "tb_checks.svh"

	always #20 rx_clk = ~rx_clk;

	////////////////////////////////////////
	// Reference model

	always @(posedge rx_clk) begin : model
		logic [7:0] b;
		logic       err;
		logic       comma;
		logic       found;
		int         src;
		if (!rst_n) begin
			m_base    = '0;
			m_aligned = 1'b0;
			m_sync    = '0;
			clr_seen  = clr_seq;
			for (int p = 0; p < 4; p++) begin
				m_good[p] = 0;
				m_bad[p]  = 0;
				m_cnt[p]  = '0;
			end
		end else begin
			if (clr_seq != clr_seen) begin
				clr_seen = clr_seq;
				for (int p = 0; p < 4; p++)
					m_cnt[p] = '0;
			end
			// Monitors consume the word the splitter put out last cycle
			for (int p = 0; p < 4; p++) begin
				b     = exp_data[p*8 +: 8];
				err   = exp_disp[p] | exp_sym[p];
				comma = exp_ctl[p] && (b == 8'hbc || b == 8'h3c || b == 8'hfc);
				if (!m_enable[p]) begin
					m_sync[p] = 1'b0;
				end else if (exp_valid) begin
					if (!m_sync[p]) begin
						if (err) begin
							m_good[p] = 0;
						end else if (comma) begin
							m_good[p]++;
							if (m_good[p] == 3) begin
								m_sync[p] = 1'b1;
								m_good[p] = 0;
								m_bad[p]  = 0;
							end
						end
					end else if (err) begin
						m_bad[p]++;
						if (m_bad[p] == 4) begin
							m_sync[p] = 1'b0;
							m_good[p] = 0;
							m_bad[p]  = 0;
						end
					end else begin
						m_bad[p] = 0;
					end
					if (err && m_cnt[p] != 16'hffff)
						m_cnt[p]++;
				end
			end
			// Lowest marker lane sets the new base
			found = 1'b0;
			for (int k = 0; k < 4; k++) begin
				if (!found && rx_data_valid && rx_data_is_ctl[k] &&
					rx_data[k*8 +: 8] == 8'h3c) begin
					found     = 1'b1;
					m_base    = 2'(k);
					m_aligned = 1'b1;
				end
			end
		end
		exp_valid = rx_data_valid;
		for (int p = 0; p < 4; p++) begin
			src         = (p + int'(m_base)) % 4;
			exp_ctl[p]  = rx_data_is_ctl[src];
			exp_disp[p] = rx_disparity_err[src];
			exp_sym[p]  = rx_symbol_err[src];
			exp_data[p*8 +: 8] = rx_data[src*8 +: 8];
			if (rx_data_valid && rx_data_is_ctl[src] && rx_data[src*8 +: 8] == 8'h3c)
				exp_data[p*8 +: 8] = 8'hbc;
		end
	end

	// Output word compared at mid cycle
	always @(negedge rx_clk) begin
		if (rst_n)
			check_lane_word(sgmii_rx_data_valid, exp_valid, sgmii_rx_data, exp_data,
				sgmii_rx_data_is_ctl, exp_ctl, sgmii_rx_disparity_err, exp_disp,
				sgmii_rx_symbol_err, exp_sym);
	end

	always @(posedge rx_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the test did not finish", cycle_cnt);
			$display("CHECKS FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////
	// Stimulus helpers

	task automatic drive_word(input logic v, input logic [3:0] ctl, input logic [31:0] d,
		input logic [3:0] de, input logic [3:0] se);
		@(posedge rx_clk);
		rx_data_valid    <= v;
		rx_data_is_ctl   <= ctl;
		rx_data          <= d;
		rx_disparity_err <= de;
		rx_symbol_err    <= se;
	endtask

	task automatic drive_idle(input int n);
		repeat (n) drive_word(1'b0, '0, '0, '0, '0);
	endtask

	// Random symbols, at most one marker per word
	task automatic drive_random_word();
		logic [3:0]  ctl;
		logic [31:0] d;
		logic [3:0]  de;
		logic [3:0]  se;
		int          m;
		for (int k = 0; k < 4; k++) begin
			d[k*8 +: 8] = 8'($random(seed));
			ctl[k] = (($random(seed) & 3) == 0);
			if (ctl[k] && d[k*8 +: 8] == 8'h3c)
				d[k*8 +: 8] = 8'h3d;
			de[k] = (($random(seed) & 7) == 0);
			se[k] = (($random(seed) & 7) == 0);
		end
		if (($random(seed) & 3) == 0) begin
			m = $random(seed) & 3;
			ctl[m] = 1'b1;
			d[m*8 +: 8] = 8'h3c;
		end
		drive_word((($random(seed) & 7) != 0), ctl, d, de, se);
	endtask

	// Comma stream with a per-port error rate out of 16
	task automatic drive_comma_word(input int t0, input int t1, input int t2, input int t3);
		logic [3:0]  de;
		logic [3:0]  se;
		logic [31:0] d;
		int          thr [4];
		int          lane;
		thr[0] = t0;
		thr[1] = t1;
		thr[2] = t2;
		thr[3] = t3;
		d  = {4{8'hbc}};
		de = '0;
		se = '0;
		for (int p = 0; p < 4; p++) begin
			lane = (p + int'(m_base)) % 4;
			if (($random(seed) & 15) < thr[p]) begin
				if ($random(seed) & 1)
					de[lane] = 1'b1;
				else
					se[lane] = 1'b1;
			end
			if (p == 0 && ($random(seed) & 7) == 0)
				d[lane*8 +: 8] = 8'h3c;
		end
		drive_word(1'b1, 4'hf, d, de, se);
	endtask

	task automatic compare_status_reg();
		logic [31:0] d;
		logic [1:0]  r;
		read_reg(reg_status, $random(seed) & 15, d, r);
		check_resp("status rresp", r, axi_resp_okay);
		check_status(d[3:0], m_sync, d[8], m_aligned, d[13:12], m_base);
	endtask

	task automatic compare_counts();
		logic [31:0] d;
		logic [1:0]  r;
		for (int p = 0; p < 4; p++) begin
			read_reg(8'(reg_err_base + p*reg_err_stride), $random(seed) & 7, d, r);
			check_resp("error rresp", r, axi_resp_okay);
			check_count($sformatf("error_count_%0d", p), d[15:0], m_cnt[p]);
			read_cnt[p] = d[15:0];
		end
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin : main
		logic [31:0] d;
		logic [1:0]  r;
		logic [15:0] frozen [4];
		rx_clk = 1'b0;
		rst_n = 1'b0;
		rx_data_valid = 1'b0;
		rx_data_is_ctl = '0;
		rx_data = '0;
		rx_disparity_err = '0;
		rx_symbol_err = '0;
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b0;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		m_enable = 4'hf;
		repeat (5) @(posedge rx_clk);
		rst_n <= 1'b1;
		compare_status_reg();

		// Alignment with random markers
		repeat (n_align) drive_random_word();
		drive_idle(n_idle);
		compare_status_reg();

		// Sync gain, then loss on port 3
		repeat (n_sync/2) drive_comma_word(0, 1, 4, 12);
		drive_idle(n_idle);
		compare_status_reg();
		repeat (n_sync/2) drive_comma_word(0, 0, 2, 16);
		drive_idle(n_idle);
		compare_status_reg();

		// Error counts and clear
		repeat (n_err) drive_comma_word(4, 4, 4, 4);
		drive_idle(n_idle);
		compare_counts();
		write_reg(reg_control, 32'h10f, r);
		check_resp("control bresp", r, axi_resp_okay);
		clr_seq++;
		drive_idle(n_idle);
		compare_counts();
		for (int p = 0; p < 4; p++)
			check_count("cleared count", read_cnt[p], 16'd0);

		// Ports 1 and 3 disabled
		write_reg(reg_control, 32'h5, r);
		m_enable = 4'h5;
		drive_idle(n_idle);
		compare_counts();
		for (int p = 0; p < 4; p++)
			frozen[p] = read_cnt[p];
		repeat (n_dis) drive_comma_word(1, 3, 1, 3);
		drive_idle(n_idle);
		compare_status_reg();
		compare_counts();
		read_reg(reg_status, 2, d, r);
		check_resp("status rresp", r, axi_resp_okay);
		check_status(d[3:0] & 4'ha, 4'h0, d[8], m_aligned, d[13:12], m_base);
		check_count("frozen error_count_1", read_cnt[1], frozen[1]);
		check_count("frozen error_count_3", read_cnt[3], frozen[3]);

		// Bus corner cases
		read_reg(8'h08, 3, d, r);
		check_resp("unmapped rresp", r, axi_resp_slverr);
		check_word("unmapped rdata", d, 32'd0);
		write_reg(8'h20, 32'hffff_ffff, r);
		check_resp("unmapped bresp", r, axi_resp_slverr);
		read_reg(reg_control, 5, d, r);
		check_word("control readback", d, 32'h5);
		repeat (8) compare_status_reg();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+dv
rtl/qsgmii_pkg.sv
rtl/qsgmii_lane_splitter.sv
rtl/sgmii_port_monitor.sv
rtl/qsgmii_csr.sv
rtl/qsgmii_rx_top.sv
dv/tb_qsgmii_rx.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_qsgmii_rx \
	-o tb_sim > sim.log 2>&1 \
	&& ./obj_dir/tb_sim >> sim.log 2>&1 \
	|| echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
